//--- src/axi_ram_pkg.sv
`default_nettype none

package axi_ram_pkg;

    // ##############################
    // Engine FSM states
    // ##############################

    // Shared by the read and the write engine
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,  // Waiting for an address handshake
        ST_XFER = 2'd1,  // Moving bytes between the RAM and the beat
        ST_RESP = 2'd2   // Presenting the R beat or the B response
    } engine_state_e;

    // ##############################
    // AXI burst encoding
    // ##############################

    typedef enum logic [1:0] {
        BURST_FIXED = 2'd0,
        BURST_INCR  = 2'd1,
        BURST_WRAP  = 2'd2  // Handled as INCR by both engines
    } burst_e;

endpackage : axi_ram_pkg

`default_nettype wire

//--- src/byte_ram.sv
`default_nettype none

module byte_ram #(
    parameter int ADDR_WIDTH = 10
) (
    input  wire logic                  clk,

    // Port a, read only
    input  wire logic [ADDR_WIDTH-1:0] ram_raddr,
    output      logic [7:0]            ram_rdata,

    // Port b, write only
    input  wire logic [ADDR_WIDTH-1:0] ram_waddr,
    input  wire logic [7:0]            ram_wdata,
    input  wire logic                  ram_we
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [7:0] mem [DEPTH];

    // Registered read, a same-cycle write to the same byte returns the old value
    always_ff @(posedge clk) begin
        ram_rdata <= mem[ram_raddr];
    end

    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[ram_waddr] <= ram_wdata;
        end
    end

endmodule : byte_ram

`default_nettype wire

//--- src/axi_read_engine.sv
`default_nettype none

module axi_read_engine
    import axi_ram_pkg::*;
#(
    parameter int ADDR_WIDTH = 10,
    parameter int DATA_WIDTH = 32,
    parameter int ID_WIDTH   = 4
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    // AR channel
    input  wire logic [ID_WIDTH-1:0]   arid,
    input  wire logic [ADDR_WIDTH-1:0] araddr,
    input  wire logic [7:0]            arlen,
    input  wire logic [2:0]            arsize,
    input  wire burst_e                arburst,
    input  wire logic                  arvalid,
    output      logic                  arready,

    // R channel
    output      logic [ID_WIDTH-1:0]   rid,
    output      logic [DATA_WIDTH-1:0] rdata,
    output      logic                  rlast,
    output      logic                  rvalid,
    input  wire logic                  rready,

    // RAM port a
    output      logic [ADDR_WIDTH-1:0] ram_raddr,
    input  wire logic [7:0]            ram_rdata
);

    localparam int BYTES  = DATA_WIDTH / 8;
    localparam int LANE_W = (BYTES > 1) ? $clog2(BYTES) : 1;
    localparam int CNT_W  = LANE_W + 1;

    engine_state_e         state_q;
    logic [CNT_W-1:0]      cnt_q;       // Bytes issued to the RAM in this beat
    logic [7:0]            beats_left_q;

    logic [ID_WIDTH-1:0]   id_q;
    logic [ADDR_WIDTH-1:0] start_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    burst_e                burst_q;
    logic [CNT_W-1:0]      n_bytes_q;   // 2^arsize
    logic [DATA_WIDTH-1:0] beat_q;

    logic [LANE_W-1:0]     cap_lane;
    logic                  r_done;

    // The byte returned now was addressed one cycle earlier
    assign cap_lane = LANE_W'(cnt_q - 1'b1);
    assign r_done   = (state_q == ST_RESP) && rready;

    // ##############################
    // Control
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= ST_IDLE;
            cnt_q        <= '0;
            beats_left_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (arvalid) begin
                        state_q      <= ST_XFER;
                        cnt_q        <= '0;
                        beats_left_q <= arlen;
                    end
                end
                ST_XFER: begin
                    if (cnt_q == n_bytes_q) begin
                        state_q <= ST_RESP;  // Last byte lands in the buffer on this edge
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                ST_RESP: begin
                    if (rready) begin
                        cnt_q <= '0;
                        if (beats_left_q == 8'd0) begin
                            state_q <= ST_IDLE;
                        end else begin
                            beats_left_q <= beats_left_q - 1'b1;
                            state_q      <= ST_XFER;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // ##############################
    // Address and beat buffer
    // ##############################

    always_ff @(posedge clk) begin
        case (state_q)
            ST_IDLE: begin
                if (arvalid) begin
                    id_q      <= arid;
                    start_q   <= araddr;
                    addr_q    <= araddr;
                    burst_q   <= arburst;
                    n_bytes_q <= CNT_W'(1) << arsize;
                    beat_q    <= '0;
                end
            end
            ST_XFER: begin
                if (cnt_q != '0) begin
                    beat_q[cap_lane*8 +: 8] <= ram_rdata;
                end
                if (cnt_q != n_bytes_q) begin
                    addr_q <= addr_q + 1'b1;  // Wraps at the top of the address space
                end
            end
            ST_RESP: begin
                if (r_done) begin
                    beat_q <= '0;  // Lanes above the beat size must read zero
                    if (burst_q == BURST_FIXED) begin
                        addr_q <= start_q;
                    end
                end
            end
            default: ;
        endcase
    end

    assign arready   = (state_q == ST_IDLE);
    assign rvalid    = (state_q == ST_RESP);
    assign rlast     = rvalid && (beats_left_q == 8'd0);
    assign rid       = id_q;
    assign rdata     = beat_q;
    assign ram_raddr = addr_q;

endmodule : axi_read_engine

`default_nettype wire

//--- src/axi_write_engine.sv
`default_nettype none

module axi_write_engine
    import axi_ram_pkg::*;
#(
    parameter int ADDR_WIDTH = 10,
    parameter int DATA_WIDTH = 32,
    parameter int ID_WIDTH   = 4
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    // AW channel
    input  wire logic [ID_WIDTH-1:0]     awid,
    input  wire logic [ADDR_WIDTH-1:0]   awaddr,
    input  wire logic [7:0]              awlen,
    input  wire logic [2:0]              awsize,
    input  wire burst_e                  awburst,
    input  wire logic                    awvalid,
    output      logic                    awready,

    // W channel
    input  wire logic [DATA_WIDTH-1:0]   wdata,
    input  wire logic [DATA_WIDTH/8-1:0] wstrb,
    input  wire logic                    wvalid,
    output      logic                    wready,

    // B channel
    output      logic [ID_WIDTH-1:0]     bid,
    output      logic                    bvalid,
    input  wire logic                    bready,

    // RAM port b
    output      logic [ADDR_WIDTH-1:0]   ram_waddr,
    output      logic [7:0]              ram_wdata,
    output      logic                    ram_we
);

    localparam int BYTES  = DATA_WIDTH / 8;
    localparam int LANE_W = (BYTES > 1) ? $clog2(BYTES) : 1;
    localparam int CNT_W  = LANE_W + 1;

    engine_state_e         state_q;
    logic [LANE_W-1:0]     lane_q;        // Lane of wdata written this cycle
    logic [7:0]            beats_left_q;

    logic [ID_WIDTH-1:0]   id_q;
    logic [ADDR_WIDTH-1:0] start_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    burst_e                burst_q;
    logic [LANE_W-1:0]     last_lane_q;   // 2^awsize - 1

    logic                  byte_go;
    logic                  beat_end;

    assign byte_go  = (state_q == ST_XFER) && wvalid;
    assign beat_end = byte_go && (lane_q == last_lane_q);

    // ##############################
    // Control
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= ST_IDLE;
            lane_q       <= '0;
            beats_left_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (awvalid) begin
                        state_q      <= ST_XFER;
                        lane_q       <= '0;
                        beats_left_q <= awlen;
                    end
                end
                ST_XFER: begin
                    if (beat_end) begin
                        lane_q <= '0;
                        if (beats_left_q == 8'd0) begin
                            state_q <= ST_RESP;
                        end else begin
                            beats_left_q <= beats_left_q - 1'b1;
                        end
                    end else if (byte_go) begin
                        lane_q <= lane_q + 1'b1;
                    end
                end
                ST_RESP: begin
                    if (bready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // ##############################
    // Address walk
    // ##############################

    always_ff @(posedge clk) begin
        if ((state_q == ST_IDLE) && awvalid) begin
            id_q        <= awid;
            start_q     <= awaddr;
            addr_q      <= awaddr;
            burst_q     <= awburst;
            last_lane_q <= LANE_W'((CNT_W'(1) << awsize) - CNT_W'(1));
        end else if (beat_end && (burst_q == BURST_FIXED)) begin
            addr_q <= start_q;  // Every FIXED beat lands on the same bytes
        end else if (byte_go) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    assign awready   = (state_q == ST_IDLE);
    assign wready    = beat_end;  // One pulse per beat, with its last byte
    assign bvalid    = (state_q == ST_RESP);
    assign bid       = id_q;
    assign ram_waddr = addr_q;
    assign ram_wdata = wdata[lane_q*8 +: 8];
    assign ram_we    = byte_go && wstrb[lane_q];

endmodule : axi_write_engine

`default_nettype wire

//--- src/axi_ram_top.sv
`default_nettype none

module axi_ram_top
    import axi_ram_pkg::*;
#(
    parameter int ADDR_WIDTH = 10,
    parameter int DATA_WIDTH = 32,
    parameter int ID_WIDTH   = 4
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    // Read address and data
    input  wire logic [ID_WIDTH-1:0]     arid,
    input  wire logic [ADDR_WIDTH-1:0]   araddr,
    input  wire logic [7:0]              arlen,
    input  wire logic [2:0]              arsize,
    input  wire burst_e                  arburst,
    input  wire logic                    arvalid,
    output      logic                    arready,
    output      logic [ID_WIDTH-1:0]     rid,
    output      logic [DATA_WIDTH-1:0]   rdata,
    output      logic                    rlast,
    output      logic                    rvalid,
    input  wire logic                    rready,

    // Write address, data and response
    input  wire logic [ID_WIDTH-1:0]     awid,
    input  wire logic [ADDR_WIDTH-1:0]   awaddr,
    input  wire logic [7:0]              awlen,
    input  wire logic [2:0]              awsize,
    input  wire burst_e                  awburst,
    input  wire logic                    awvalid,
    output      logic                    awready,
    input  wire logic [DATA_WIDTH-1:0]   wdata,
    input  wire logic [DATA_WIDTH/8-1:0] wstrb,
    input  wire logic                    wvalid,
    output      logic                    wready,
    output      logic [ID_WIDTH-1:0]     bid,
    output      logic                    bvalid,
    input  wire logic                    bready
);

    logic [ADDR_WIDTH-1:0] ram_raddr;
    logic [7:0]            ram_rdata;
    logic [ADDR_WIDTH-1:0] ram_waddr;
    logic [7:0]            ram_wdata;
    logic                  ram_we;

    // Read side owns RAM port a
    axi_read_engine #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) u_read (
        .clk       (clk),
        .rst_n     (rst_n),
        .arid      (arid),
        .araddr    (araddr),
        .arlen     (arlen),
        .arsize    (arsize),
        .arburst   (arburst),
        .arvalid   (arvalid),
        .arready   (arready),
        .rid       (rid),
        .rdata     (rdata),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready),
        .ram_raddr (ram_raddr),
        .ram_rdata (ram_rdata)
    );

    // Write side owns RAM port b
    axi_write_engine #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) u_write (
        .clk       (clk),
        .rst_n     (rst_n),
        .awid      (awid),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awsize    (awsize),
        .awburst   (awburst),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bid       (bid),
        .bvalid    (bvalid),
        .bready    (bready),
        .ram_waddr (ram_waddr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we)
    );

    byte_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ram (
        .clk       (clk),
        .ram_raddr (ram_raddr),
        .ram_rdata (ram_rdata),
        .ram_waddr (ram_waddr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we)
    );

endmodule : axi_ram_top

`default_nettype wire

//--- bench/tb_axi_ram.sv
`default_nettype none

module tb_axi_ram
    import axi_ram_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_WIDTH = 10;
    localparam int DATA_WIDTH = 32;
    localparam int ID_WIDTH   = 4;
    localparam int BYTES      = DATA_WIDTH / 8;
    localparam int DEPTH      = 2 ** ADDR_WIDTH;
    localparam logic [2:0] SIZE_FULL = 3'($clog2(BYTES));
    localparam int TIMEOUT    = 1000;  // Cycles allowed for any single wait

    logic                  clk;
    logic                  rst_n;
    logic [ID_WIDTH-1:0]   arid;
    logic [ADDR_WIDTH-1:0] araddr;
    logic [7:0]            arlen;
    logic [2:0]            arsize;
    burst_e                arburst;
    logic                  arvalid;
    logic                  arready;
    logic [ID_WIDTH-1:0]   rid;
    logic [DATA_WIDTH-1:0] rdata;
    logic                  rlast;
    logic                  rvalid;
    logic                  rready;
    logic [ID_WIDTH-1:0]   awid;
    logic [ADDR_WIDTH-1:0] awaddr;
    logic [7:0]            awlen;
    logic [2:0]            awsize;
    burst_e                awburst;
    logic                  awvalid;
    logic                  awready;
    logic [DATA_WIDTH-1:0] wdata;
    logic [BYTES-1:0]      wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [ID_WIDTH-1:0]   bid;
    logic                  bvalid;
    logic                  bready;

    logic [7:0]            model [DEPTH];  // Byte image of what the RAM should hold
    logic [DATA_WIDTH-1:0] exp_data [$];
    logic [ID_WIDTH-1:0]   exp_id [$];
    bit                    exp_last [$];
    string                 test_name;

    axi_ram_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready),
        .awid    (awid),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awsize  (awsize),
        .awburst (awburst),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bid     (bid),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ##############################
    // Reporting and compare tasks
    // ##############################

    task automatic stop_with_errors();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input string what, input logic [DATA_WIDTH-1:0] exp,
                              input logic [DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
            stop_with_errors();
        end
    endtask

    task automatic check_id(input string what, input logic [ID_WIDTH-1:0] exp,
                            input logic [ID_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
            stop_with_errors();
        end
    endtask

    task automatic check_last(input string what, input bit exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act);
            stop_with_errors();
        end
    endtask

    task automatic match_level(input string what, input bit exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act);
            stop_with_errors();
        end
    endtask

    task automatic match_cycles(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("FAIL %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            stop_with_errors();
        end
    endtask

    // ##############################
    // Reference model
    // ##############################

    // FIXED repeats the start range, INCR and WRAP run on byte by byte
    function automatic logic [ADDR_WIDTH-1:0] byte_addr(input logic [ADDR_WIDTH-1:0] start,
            input burst_e burst, input int nbytes, input int beat, input int k);
        int offset;
        offset = (burst == BURST_FIXED) ? k : beat * nbytes + k;
        return start + ADDR_WIDTH'(offset);
    endfunction

    function automatic logic [DATA_WIDTH-1:0] expected_beat(input logic [ADDR_WIDTH-1:0] start,
            input burst_e burst, input logic [2:0] size, input int beat);
        logic [DATA_WIDTH-1:0] result;
        int                    nbytes;
        result = '0;  // Lanes above the beat size stay zero
        nbytes = 1 << size;
        for (int k = 0; k < nbytes; k++) begin
            result[k*8 +: 8] = model[byte_addr(start, burst, nbytes, beat, k)];
        end
        return result;
    endfunction

    // Every R handshake is checked against the queued expectations
    always @(posedge clk) begin
        if (rst_n && rvalid && rready) begin
            if (exp_data.size() == 0) begin
                $display("An R beat arrived while no read was outstanding");
                stop_with_errors();
            end else begin
                check_data("rdata", exp_data.pop_front(), rdata);
                check_id("rid", exp_id.pop_front(), rid);
                check_last("rlast", exp_last.pop_front(), rlast);
            end
        end
    end

    // ##############################
    // Bus driver tasks
    // ##############################

    task automatic send_beat(input logic [DATA_WIDTH-1:0] data, input logic [BYTES-1:0] strb,
                             input bit gaps);
        int tmo;
        bit done;
        tmo  = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            wdata  = data;
            wstrb  = strb;
            wvalid = gaps ? ($urandom_range(0, 3) != 0) : 1'b1;
            @(posedge clk);
            if (wvalid && wready) begin
                done = 1'b1;
            end else begin
                tmo++;
                if (tmo > TIMEOUT) begin
                    $display("Timed out waiting for WREADY in test %s", test_name);
                    stop_with_errors();
                end
            end
        end
    endtask

    task automatic write_burst(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
            input logic [7:0] len, input logic [2:0] size, input burst_e burst,
            input bit full_strb, input bit stall);
        logic [DATA_WIDTH-1:0] data;
        logic [BYTES-1:0]      strb;
        int                    nbytes;
        int                    tmo;
        bit                    done;
        nbytes = 1 << size;
        @(negedge clk);
        awid    = id;
        awaddr  = addr;
        awlen   = len;
        awsize  = size;
        awburst = burst;
        awvalid = 1'b1;
        tmo = 0;
        @(posedge clk);
        while (!awready) begin
            tmo++;
            if (tmo > TIMEOUT) begin
                $display("Timed out waiting for AWREADY in test %s", test_name);
                stop_with_errors();
            end
            @(posedge clk);
        end
        @(negedge clk);
        awvalid = 1'b0;
        for (int b = 0; b <= int'(len); b++) begin
            data = DATA_WIDTH'($urandom);
            strb = full_strb ? '1 : BYTES'($urandom);
            for (int k = 0; k < nbytes; k++) begin
                if (strb[k]) begin
                    model[byte_addr(addr, burst, nbytes, b, k)] = data[k*8 +: 8];
                end
            end
            send_beat(data, strb, stall);
        end
        tmo  = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            wvalid = 1'b0;
            bready = stall ? ($urandom_range(0, 1) == 1) : 1'b1;
            @(posedge clk);
            if (bvalid && bready) begin
                done = 1'b1;
                check_id("bid", id, bid);
            end else begin
                tmo++;
                if (tmo > TIMEOUT) begin
                    $display("Timed out waiting for the B response in test %s", test_name);
                    stop_with_errors();
                end
            end
        end
    endtask

    // Latency counts rising edges from the AR handshake until RVALID is up
    task automatic read_burst(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
            input logic [7:0] len, input logic [2:0] size, input burst_e burst,
            input bit stall, output int latency);
        int tmo;
        int got;
        bit seen;
        for (int b = 0; b <= int'(len); b++) begin
            exp_data.push_back(expected_beat(addr, burst, size, b));
            exp_id.push_back(id);
            exp_last.push_back(b == int'(len));
        end
        @(negedge clk);
        arid    = id;
        araddr  = addr;
        arlen   = len;
        arsize  = size;
        arburst = burst;
        arvalid = 1'b1;
        tmo = 0;
        @(posedge clk);
        while (!arready) begin
            tmo++;
            if (tmo > TIMEOUT) begin
                $display("Timed out waiting for ARREADY in test %s", test_name);
                stop_with_errors();
            end
            @(posedge clk);
        end
        latency = 0;
        seen    = 1'b0;
        got     = 0;
        tmo     = 0;
        while (got <= int'(len)) begin
            @(negedge clk);
            arvalid = 1'b0;
            if (rvalid) seen = 1'b1;
            rready = stall ? ($urandom_range(0, 1) == 1) : 1'b1;
            @(posedge clk);
            if (!seen) latency++;
            if (rvalid && rready) begin
                got++;
                tmo = 0;
            end else begin
                tmo++;
                if (tmo > TIMEOUT) begin
                    $display("Timed out waiting for an R beat in test %s", test_name);
                    stop_with_errors();
                end
            end
        end
    endtask

    // ##############################
    // Test sequence
    // ##############################

    initial begin
        logic [ADDR_WIDTH-1:0] addr;
        logic [ID_WIDTH-1:0]   id;
        logic [7:0]            len;
        logic [2:0]            size;
        burst_e                burst;
        int                    latency;
        void'($urandom(32'h2cb5));
        rst_n   = 1'b0;
        arid    = '0;
        araddr  = '0;
        arlen   = '0;
        arsize  = '0;
        arburst = BURST_INCR;
        arvalid = 1'b0;
        rready  = 1'b0;
        awid    = '0;
        awaddr  = '0;
        awlen   = '0;
        awsize  = '0;
        awburst = BURST_INCR;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "reset";
        @(negedge clk);
        match_level("arready", 1'b1, arready);
        match_level("awready", 1'b1, awready);
        match_level("rvalid", 1'b0, rvalid);
        match_level("bvalid", 1'b0, bvalid);

        // Whole RAM gets defined contents before any read
        test_name = "fill";
        write_burst('0, '0, 8'(DEPTH / BYTES - 1), SIZE_FULL, BURST_INCR, 1'b1, 1'b0);

        test_name = "single_beat";
        repeat (8) begin
            addr = ADDR_WIDTH'($urandom);
            id   = ID_WIDTH'($urandom);
            write_burst(id, addr, 8'd0, SIZE_FULL, BURST_INCR, 1'b1, 1'b0);
            read_burst(~id, addr, 8'd0, SIZE_FULL, BURST_INCR, 1'b0, latency);
        end

        test_name = "random_incr";
        write_burst(4'h3, ADDR_WIDTH'(DEPTH - 3), 8'd3, SIZE_FULL, BURST_INCR, 1'b0, 1'b0);
        read_burst(4'h5, ADDR_WIDTH'(DEPTH - 6), 8'd3, SIZE_FULL, BURST_INCR, 1'b0, latency);
        repeat (40) begin
            addr  = ADDR_WIDTH'($urandom);
            id    = ID_WIDTH'($urandom);
            len   = 8'($urandom_range(0, 15));
            size  = 3'($urandom_range(0, int'(SIZE_FULL)));
            burst = burst_e'($urandom_range(1, 2));  // WRAP behaves as INCR
            write_burst(id, addr, len, size, burst, 1'b0, 1'b0);
            read_burst(id, addr, len, size, burst, 1'b0, latency);
        end

        test_name = "fixed";
        repeat (6) begin
            addr = ADDR_WIDTH'($urandom);
            id   = ID_WIDTH'($urandom);
            size = 3'($urandom_range(0, int'(SIZE_FULL)));
            write_burst(id, addr, 8'd3, size, BURST_FIXED, 1'b0, 1'b0);
            read_burst(id, addr, 8'd3, size, BURST_FIXED, 1'b0, latency);
            read_burst(id, addr - 1'b1, 8'd2, size, BURST_INCR, 1'b0, latency);
        end

        test_name = "backpressure";
        repeat (30) begin
            addr  = ADDR_WIDTH'($urandom);
            id    = ID_WIDTH'($urandom);
            len   = 8'($urandom_range(0, 7));
            size  = 3'($urandom_range(0, int'(SIZE_FULL)));
            burst = burst_e'($urandom_range(0, 2));
            write_burst(id, addr, len, size, burst, 1'b0, 1'b1);
            read_burst(id, addr, len, size, burst, 1'b1, latency);
        end

        test_name = "latency";
        read_burst(4'h9, ADDR_WIDTH'($urandom), 8'd0, SIZE_FULL, BURST_INCR, 1'b0, latency);
        match_cycles("rvalid delay", BYTES + 1, latency);

        // The compare process has seen the final R beat by the next falling edge
        @(negedge clk);
        if (exp_data.size() != 0) begin
            $display("Some expected R beats were never checked");
            stop_with_errors();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule : tb_axi_ram

`default_nettype wire

//--- sim.f
src/axi_ram_pkg.sv
src/byte_ram.sv
src/axi_read_engine.sv
src/axi_write_engine.sv
src/axi_ram_top.sv
bench/tb_axi_ram.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_axi_ram
FILELIST = sim.f
OBJ      = obj_dir
PASS     = No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ)
	@out="$$(./$(OBJ)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJ)
